// ==== mem_subsys.f ====
hw/core_access_pkg.sv
hw/mem_bus_pkg.sv
hw/mem_handler.sv
hw/bus_bridge.sv
hw/data_ram.sv
hw/mem_subsys_top.sv
tb/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mem_subsys_tb
FILELIST  := mem_subsys.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status follows the pass message in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/mem_subsys_tb.sv ====
// self-checking testbench for the memory-access subsystem against a byte-array model
// only aligned accesses are generated, pc always stays inside the mapped range
// RAM answer delay is the data_ram default, the round timeout assumes a short delay

`timescale 1ns/1ps

module mem_subsys_tb;
    import core_access_pkg::*;
    import mem_bus_pkg::*;

    localparam int ROUND_TIMEOUT = 64;  // cycles allowed for one round

    // what the core should see in a freeze-low cycle
    typedef struct packed {
        logic [31:0] load;
        logic [31:0] instr;
    } round_exp_t;

    logic        clk;
    logic        nrst;
    core_req_t   core_req;
    logic [31:0] load_data;
    logic [31:0] instruction;
    logic        freeze;

    logic [7:0]  ref_mem [RAM_BYTES];   // byte model of the RAM
    logic [31:0] model_load;            // load_data as the model tracks it
    round_exp_t  exp_pend;              // request now presented by the core
    round_exp_t  exp_run;               // request the DUT is executing
    logic        was_low;
    int          checks;
    int          errors;
    int          err_mark;
    int          tests;
    int          failed_tests;

    mem_subsys_top UUT (
        .clk         (clk),
        .nrst        (nrst),
        .core_req    (core_req),
        .load_data   (load_data),
        .instruction (instruction),
        .freeze      (freeze)
    );

    always #50 clk = ~clk;  // 100 ns period

    // expected load value, little-endian lanes then extension
    function automatic logic [31:0] ref_load(input access_width_e w, input logic [31:0] a);
        logic [10:0] base;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [31:0] v;
        base = a[10:0];
        b0   = ref_mem[base];
        b1   = ref_mem[base + 11'd1];
        case (w)
            ACC_B:   v = {{24{b0[7]}}, b0};
            ACC_BU:  v = {24'b0, b0};
            ACC_H:   v = {{16{b1[7]}}, b1, b0};
            ACC_HU:  v = {16'b0, b1, b0};
            default: v = {ref_mem[base + 11'd3], ref_mem[base + 11'd2], b1, b0};
        endcase
        return v;
    endfunction

    // store effect, only the bytes the width covers
    task automatic model_store(input access_width_e w, input logic [31:0] a,
                               input logic [31:0] d);
        int n;
        case (w)
            ACC_B, ACC_BU: n = 1;
            ACC_H, ACC_HU: n = 2;
            default:       n = 4;
        endcase
        for (int i = 0; i < n; i++)
            ref_mem[a[10:0] + 11'(i)] = d[8*i +: 8];
    endtask

    function automatic core_req_t make_req(input logic rd, input logic wr,
                                           input access_width_e w, input logic [31:0] a,
                                           input logic [31:0] d, input logic [31:0] pc);
        core_req_t r;
        r.read  = rd;
        r.write = wr;
        r.width = w;
        r.addr  = a;
        r.wdata = d;
        r.pc    = pc;
        return r;
    endfunction

    function automatic logic [31:0] word_addr();
        logic [31:0] r;
        r = $urandom;
        return {21'b0, r[10:2], 2'b00};     // aligned, mapped
    endfunction

    // mixed access, roughly one in sixteen unmapped
    function automatic core_req_t random_op(input logic [31:0] pc);
        logic [31:0]   sel;
        logic [31:0]   a;
        logic          wr;
        access_width_e w;
        sel = $urandom;
        a   = $urandom;
        wr  = sel[3];
        case (sel[2:0])
            3'd0, 3'd1: w = ACC_B;
            3'd2:       w = ACC_H;
            3'd3:       w = ACC_W;
            3'd4:       w = wr ? ACC_B : ACC_BU;   // no unsigned stores
            3'd5:       w = wr ? ACC_H : ACC_HU;
            default:    w = ACC_W;
        endcase
        a = {20'b0, (sel[7:4] == 4'd0), a[10:0]};  // bit 11 set lands above the RAM
        if (w == ACC_H || w == ACC_HU)
            a[0] = 1'b0;
        if (w == ACC_W)
            a[1:0] = 2'b00;
        return make_req(!wr, wr, w, a, $urandom, pc);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // posedge values are pre-update, so state and done belong to the ending cycle
    task automatic wait_round_end();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < ROUND_TIMEOUT && !seen; n++) begin
            @(posedge clk);
            seen = (UUT.u_handler.state == HS_FETCH_WAIT) && UUT.done;
        end
        if (!seen) begin
            $display("timeout at %0t ns, no round finished in %0d cycles", $time, ROUND_TIMEOUT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    // present the next request in the cycle freeze goes low
    task automatic run_op(input core_req_t r);
        wait_round_end();
        core_req <= r;
        if (r.addr < RAM_BYTES) begin   // unmapped requests leave the model alone
            if (r.write)
                model_store(r.width, r.addr, r.wdata);
            else if (r.read)
                model_load = ref_load(r.width, r.addr);
        end
        exp_pend.load  = model_load;
        exp_pend.instr = ref_load(ACC_W, r.pc);     // fetch sees this round's store
    endtask

    // held request reruns harmlessly, wait past one freeze-low sample
    task automatic finish_test(input string name);
        wait_round_end();
        @(negedge clk);
        @(negedge clk);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // compare once per freeze-low cycle
    always @(posedge clk) begin
        if (nrst !== 1'b1) begin
            was_low = 1'b0;
        end else if (!freeze) begin
            check_value("load_data", load_data, exp_run.load);
            check_value("instruction", instruction, exp_run.instr);
            assert (!was_low) else begin
                $display("freeze stayed low for more than one cycle at %0t ns", $time);
                errors++;
            end
            was_low = 1'b1;
            exp_run = exp_pend;     // request sampled at this edge runs next
        end else begin
            was_low = 1'b0;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        void'($urandom(32'he44a));
        clk          = 1'b0;
        nrst         = 1'b0;
        core_req     = make_req(1'b0, 1'b0, ACC_W, 32'h0, 32'h0, 32'h0);
        for (int i = 0; i < RAM_BYTES; i++)
            ref_mem[i] = 8'h00;     // RAM powers up zero
        model_load   = '0;
        exp_pend     = '0;
        exp_run      = '0;
        was_low      = 1'b0;
        checks       = 0;
        errors       = 0;
        err_mark     = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;

        finish_test("reset round");

        repeat (8) begin
            a = word_addr();
            run_op(make_req(1'b0, 1'b1, ACC_W, a, $urandom, word_addr()));
            run_op(make_req(1'b1, 1'b0, ACC_W, a, 32'h0, word_addr()));
        end
        finish_test("sw then lw");

        repeat (4) begin
            a = word_addr();
            run_op(make_req(1'b0, 1'b1, ACC_W, a, $urandom, a));
            for (int lane = 0; lane < 4; lane++)
                run_op(make_req(1'b0, 1'b1, ACC_B, a + 32'(lane), $urandom, word_addr()));
            run_op(make_req(1'b1, 1'b0, ACC_W, a, 32'h0, a));
            for (int h = 0; h < 4; h += 2)
                run_op(make_req(1'b0, 1'b1, ACC_H, a + 32'(h), $urandom, word_addr()));
            run_op(make_req(1'b1, 1'b0, ACC_W, a, 32'h0, a));
        end
        finish_test("sb and sh merge");

        for (int i = 0; i < 3; i++) begin
            a = word_addr();
            d = (i == 0) ? 32'h8081_7f01 : $urandom;    // both signs on bytes and halves
            run_op(make_req(1'b0, 1'b1, ACC_W, a, d, word_addr()));
            for (int lane = 0; lane < 4; lane++) begin
                run_op(make_req(1'b1, 1'b0, ACC_B, a + 32'(lane), 32'h0, word_addr()));
                run_op(make_req(1'b1, 1'b0, ACC_BU, a + 32'(lane), 32'h0, word_addr()));
            end
            for (int h = 0; h < 4; h += 2) begin
                run_op(make_req(1'b1, 1'b0, ACC_H, a + 32'(h), 32'h0, word_addr()));
                run_op(make_req(1'b1, 1'b0, ACC_HU, a + 32'(h), 32'h0, word_addr()));
            end
        end
        finish_test("sub-word loads");

        a = word_addr();
        b = a ^ 32'h4;                  // neighbour word, its alias would differ
        d = $urandom;
        run_op(make_req(1'b0, 1'b1, ACC_W, a, d, a));
        run_op(make_req(1'b0, 1'b1, ACC_W, b, ~d, b));
        run_op(make_req(1'b1, 1'b0, ACC_W, a, 32'h0, a));
        run_op(make_req(1'b1, 1'b0, ACC_W, b + RAM_BYTES, 32'h0, b));  // keeps d
        run_op(make_req(1'b1, 1'b0, ACC_B, 32'hffff_fff1, 32'h0, a));
        run_op(make_req(1'b0, 1'b1, ACC_W, a + RAM_BYTES, $urandom, a));
        run_op(make_req(1'b0, 1'b1, ACC_B, a + 32'h8000_0000, $urandom, a));
        run_op(make_req(1'b1, 1'b0, ACC_W, a, 32'h0, b));
        finish_test("unmapped addresses");

        repeat (8) begin
            a = word_addr();
            run_op(make_req(1'b0, 1'b1, ACC_W, a, $urandom, a));  // fetched in the same round
            run_op(random_op(a));
        end
        finish_test("fetch after store");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && failed_tests == 0 && checks > 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/mem_subsys_top.sv ====
// memory-access subsystem, handler to bridge to data RAM
// the core sees one freeze-low cycle per round, results valid in that cycle
// RAM answer delay is the data_ram default

`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                       clk,
    input  logic                       nrst,
    input  core_access_pkg::core_req_t core_req,
    output logic [31:0]                load_data,
    output logic [31:0]                instruction,
    output logic                       freeze
);
    import mem_bus_pkg::*;

    // handler to bridge
    logic        start;
    mem_req_t    bus_req;
    logic [31:0] rdata;
    logic        busy;
    logic        done;

    // bridge to RAM
    logic        req;
    mem_req_t    ram_req;
    logic        ack;
    logic [31:0] ack_rdata;

    mem_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .core_req    (core_req),
        .rdata       (rdata),
        .busy        (busy),
        .done        (done),
        .start       (start),
        .bus_req     (bus_req),
        .load_data   (load_data),
        .instruction (instruction),
        .freeze      (freeze)
    );

    bus_bridge u_bridge (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .bus_req   (bus_req),
        .rdata     (rdata),
        .busy      (busy),
        .done      (done),
        .req       (req),
        .ram_req   (ram_req),
        .ack       (ack),
        .ack_rdata (ack_rdata)
    );

    data_ram u_ram (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .ram_req   (ram_req),
        .ack       (ack),
        .ack_rdata (ack_rdata)
    );

endmodule

// ==== hw/data_ram.sv ====
// word RAM with byte strobes behind a four-phase req/ack port
// ack rises after ack_delay waiting cycles (0 to 7) and falls the cycle after req
// power-up contents are zero, address bits above the RAM size are ignored

`timescale 1ns/1ps

module data_ram #(
    parameter int unsigned ack_delay = 2
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  req,
    input  mem_bus_pkg::mem_req_t ram_req,
    output logic                  ack,
    output logic [31:0]           ack_rdata
);
    import mem_bus_pkg::*;

    localparam int unsigned WORD_AW = $clog2(RAM_WORDS);

    logic [31:0]        mem [RAM_WORDS];
    logic [2:0]         cnt;        // wait cycles left
    logic               ack_fire;   // ack rises at this edge
    logic [WORD_AW-1:0] idx;

    assign idx      = ram_req.addr[WORD_AW+1:2];
    assign ack_fire = req && !ack && (cnt == 3'd0);

    initial begin
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] = '0;
    end

    // handshake and delay counter
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack <= 1'b0;
            cnt <= 3'(ack_delay);
        end else if (ack) begin
            if (!req) begin
                ack <= 1'b0;            // phase four
                cnt <= 3'(ack_delay);   // rearm for the next req
            end
        end else if (req) begin
            if (cnt == 3'd0)
                ack <= 1'b1;
            else
                cnt <= cnt - 3'd1;
        end
    end

    // array access happens once, on the ack edge
    always_ff @(posedge clk) begin
        if (ack_fire) begin
            ack_rdata <= mem[idx];  // old word, stores return it unchanged
            if (ram_req.we) begin
                for (int b = 0; b < 4; b++)
                    if (ram_req.wstrb[b])
                        mem[idx][8*b +: 8] <= ram_req.wdata[8*b +: 8];
            end
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ack) |-> $past(req))
        else $error("ack raised without req");

    // handler filters unmapped data addresses before they reach the bus
    a_in_range: assert property (@(posedge clk) disable iff (!nrst)
        req |-> (ram_req.addr < RAM_BYTES))
        else $error("unmapped address %h on the RAM port", ram_req.addr);

endmodule

// ==== hw/bus_bridge.sv ====
// turns a one-cycle start strobe into a four-phase req/ack handshake
// start is ignored while busy, done pulses once after ack has fallen
// rdata holds the last captured word until the next read

`timescale 1ns/1ps

module bus_bridge (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  start,
    input  mem_bus_pkg::mem_req_t bus_req,
    output logic [31:0]           rdata,
    output logic                  busy,
    output logic                  done,
    output logic                  req,
    output mem_bus_pkg::mem_req_t ram_req,
    input  logic                  ack,
    input  logic [31:0]           ack_rdata
);
    import mem_bus_pkg::*;

    bridge_state_e state, state_nxt;

    mem_req_t req_q;   // request latched on start

    assign busy    = (state != BR_IDLE);
    assign done    = (state == BR_DONE);
    assign req     = (state == BR_REQ);
    assign ram_req = req_q;

    always_comb begin
        state_nxt = state;
        case (state)
            BR_IDLE: begin
                if (start)
                    state_nxt = BR_REQ;     // req rises next cycle
            end
            BR_REQ: begin
                if (ack)
                    state_nxt = BR_RELEASE; // drop req once acked
            end
            BR_RELEASE: begin
                if (!ack)
                    state_nxt = BR_DONE;    // handshake closed
            end
            BR_DONE: begin
                state_nxt = BR_IDLE;
            end
            default: state_nxt = BR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst)
            state <= BR_IDLE;
        else
            state <= state_nxt;
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (state == BR_IDLE && start)
            req_q <= bus_req;
        if (state == BR_REQ && ack)
            rdata <= ack_rdata;     // valid only while ack high
    end

    // four-phase rule, release only after the RAM answered
    a_req_hold: assert property (@(posedge clk) disable iff (!nrst)
        $fell(req) |-> $past(ack))
        else $error("req dropped before ack");

    // RAM samples the request at an unknown point in the req window
    a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
        (req && $past(req)) |-> $stable(ram_req))
        else $error("ram_req changed while req high");

endmodule

// ==== hw/mem_handler.sv ====
// load/store and fetch sequencer, at most one data access then one fetch per round
// core_req must stay stable from the freeze-low cycle until the next freeze-low cycle
// unmapped data addresses skip the bus, the fetch address is not range checked
// misaligned halfword or word accesses are not supported

`timescale 1ns/1ps

module mem_handler (
    input  logic                      clk,
    input  logic                      nrst,
    input  core_access_pkg::core_req_t core_req,
    input  logic [31:0]               rdata,
    input  logic                      busy,
    input  logic                      done,
    output logic                      start,
    output mem_bus_pkg::mem_req_t     bus_req,
    output logic [31:0]               load_data,
    output logic [31:0]               instruction,
    output logic                      freeze
);
    import core_access_pkg::*;
    import mem_bus_pkg::*;

    handler_state_e state, state_nxt;

    logic        mapped;
    logic        do_store;
    logic        do_load;
    logic        data_acc;
    logic [1:0]  off;
    logic [4:0]  shamt;
    logic [31:0] lane;      // rdata shifted down to lane 0
    logic [31:0] load_ext;
    logic [31:0] st_wdata;
    logic [3:0]  st_wstrb;

    // request classification
    assign mapped   = (core_req.addr < RAM_BYTES);
    assign do_store = core_req.write;                   // store has priority
    assign do_load  = core_req.read && !core_req.write;
    assign data_acc = (do_store || do_load) && mapped;
    assign off      = core_req.addr[1:0];
    assign shamt    = {off, 3'b000};

    // replicate store data on every lane, strobe picks the live ones
    always_comb begin
        case (core_req.width)
            ACC_B, ACC_BU: begin
                st_wdata = {4{core_req.wdata[7:0]}};
                st_wstrb = 4'b0001 << off;
            end
            ACC_H, ACC_HU: begin
                st_wdata = {2{core_req.wdata[15:0]}};
                st_wstrb = 4'b0011 << {off[1], 1'b0};
            end
            default: begin                              // word
                st_wdata = core_req.wdata;
                st_wstrb = 4'b1111;
            end
        endcase
    end

    // load lane select and extension
    assign lane = rdata >> shamt;

    always_comb begin
        case (core_req.width)
            ACC_B:   load_ext = {{24{lane[7]}}, lane[7:0]};
            ACC_H:   load_ext = {{16{lane[15]}}, lane[15:0]};
            ACC_BU:  load_ext = {24'b0, lane[7:0]};
            ACC_HU:  load_ext = {16'b0, lane[15:0]};
            default: load_ext = rdata;                  // LW
        endcase
    end

    // bus request follows the phase, core_req is held so this stays stable
    always_comb begin
        bus_req = '0;
        if (state == HS_FETCH_REQ || state == HS_FETCH_WAIT) begin
            bus_req.addr = core_req.pc;                 // fetch is a plain word read
        end else begin
            bus_req.we    = do_store;
            bus_req.addr  = core_req.addr;
            bus_req.wdata = do_store ? st_wdata : 32'b0;
            bus_req.wstrb = do_store ? st_wstrb : 4'b0;
        end
    end

    // one strobe per transfer
    assign start  = (state == HS_IDLE && data_acc) || (state == HS_FETCH_REQ);
    assign freeze = (state != HS_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            HS_IDLE:       state_nxt = data_acc ? HS_DATA_WAIT : HS_FETCH_REQ;
            HS_DATA_WAIT:  if (done) state_nxt = HS_FETCH_REQ;
            HS_FETCH_REQ:  state_nxt = HS_FETCH_WAIT;
            HS_FETCH_WAIT: if (done) state_nxt = HS_IDLE;
            default:       state_nxt = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= HS_IDLE;
            load_data   <= '0;
            instruction <= '0;
        end else begin
            state <= state_nxt;
            if (state == HS_DATA_WAIT && done && do_load)
                load_data <= load_ext;                  // unmapped loads never get here
            if (state == HS_FETCH_WAIT && done)
                instruction <= rdata;
        end
    end

    // halfword on even address, word on a multiple of four
    a_aligned: assert property (@(posedge clk) disable iff (!nrst)
        (state == HS_IDLE && data_acc) |->
            !(((core_req.width == ACC_H) || (core_req.width == ACC_HU)) && off[0]) &&
            !((core_req.width == ACC_W) && (off != 2'b00)))
        else $error("misaligned access at %h", core_req.addr);

    // bridge must have finished the previous transfer
    a_start_idle: assert property (@(posedge clk) disable iff (!nrst)
        start |-> !busy)
        else $error("start raised while bridge busy");

    // a transfer never outlives its round
    a_no_done_idle: assert property (@(posedge clk) disable iff (!nrst)
        (state == HS_IDLE) |-> !done)
        else $error("done seen in HS_IDLE");

endmodule

// ==== hw/mem_bus_pkg.sv ====
// memory-bus definitions between handler, bridge and data RAM
// the RAM maps byte addresses 0 to RAM_BYTES-1 and anything above is unmapped
// the bus carries whole words with a byte strobe for stores

package mem_bus_pkg;

    // mapped range
    localparam int unsigned RAM_BYTES = 2048;
    localparam int unsigned RAM_WORDS = 512;  // RAM_BYTES / 4

    // one bus transfer, word aligned data with lane strobes
    typedef struct packed {
        logic        we;     // 1 store, 0 load or fetch
        logic [31:0] addr;   // byte address, low bits pick the lane
        logic [31:0] wdata;  // already shifted onto its lanes
        logic [3:0]  wstrb;  // one bit per byte lane
    } mem_req_t;

    // four-phase req/ack sequence seen from the bridge
    typedef enum logic [1:0] {
        BR_IDLE,     // ready for a start strobe
        BR_REQ,      // req high, waiting for ack
        BR_RELEASE,  // req low, waiting for ack to fall
        BR_DONE      // one-cycle done pulse
    } bridge_state_e;

endpackage

// ==== hw/core_access_pkg.sv ====
// core-side types shared by the memory handler, the top level and the testbench
// width codes follow the RISC-V func3 field for loads and stores
// only naturally aligned accesses are supported

package core_access_pkg;

    // func3 access width and signedness
    typedef enum logic [2:0] {
        ACC_B  = 3'd0,  // byte, sign-extended on load
        ACC_H  = 3'd1,  // halfword, sign-extended on load
        ACC_W  = 3'd2,  // full word
        ACC_BU = 3'd4,  // byte, zero-extended
        ACC_HU = 3'd5   // halfword, zero-extended
    } access_width_e;

    // handler sequence, one round per instruction
    typedef enum logic [1:0] {
        HS_IDLE,        // freeze low, request sampled here
        HS_DATA_WAIT,   // load or store in flight
        HS_FETCH_REQ,   // fetch strobe issued
        HS_FETCH_WAIT   // waiting for the instruction word
    } handler_state_e;

    // request from the core, held while freeze is high
    typedef struct packed {
        logic          read;
        logic          write;  // wins if both are set
        access_width_e width;
        logic [31:0]   addr;
        logic [31:0]   wdata;
        logic [31:0]   pc;
    } core_req_t;

endpackage
